// ==== files.f ====
+incdir+include
logic/ptp_time_pkg.sv
logic/ptp_ctrl_pkg.sv
logic/ptp_clock.sv
logic/ptp_event_fifo.sv
logic/ptp_perout.sv
logic/ptp_subsys.sv
testbench/ptp_subsys_sva.sv
testbench/ptp_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: ptp_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/ptp_time_pkg.sv
      - logic/ptp_ctrl_pkg.sv
      - logic/ptp_clock.sv
      - logic/ptp_event_fifo.sv
      - logic/ptp_perout.sv
      - logic/ptp_subsys.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/ptp_subsys_sva.sv
      - testbench/ptp_subsys_tb.sv

// ==== testbench/ptp_subsys_tb.sv ====
// PTP clock subsystem testbench
// Runs the hardware clock from reset through loads, offset slews and
// period/drift changes, captures events into the FIFO and schedules a
// periodic output. A cycle model predicts every output and a compare
// process checks the DUT against it on each falling clock edge.

`timescale 1ns/1ps
`include "ptp_macros.svh"

module ptp_subsys_tb
    import ptp_time_pkg::*, ptp_ctrl_pkg::*;
();

    // the tests take about 800 cycles
    localparam int MAX_CYCLES = 4000;

    typedef struct packed {
        ns_frac_t    period;
        ns_frac_t    adj;
        ns_frac_t    drift;
        logic [15:0] drift_rate;
        logic [15:0] drift_cnt;
        logic [15:0] adj_cnt;
        logic        adj_on;
        inc_t        inc1;
        inc_t        inc2;
        inc_t        inc3;
        ts64_t       ts64;
        logic [47:0] sec;
        logic [45:0] v96;
        logic        hold;
        logic        pps;
        logic        step;
    } model_t;

    logic        clk = 1'b0;
    logic        rst;
    ts96_t       ts_96_load;
    logic        ts_96_load_valid;
    ts64_t       ts_64_load;
    logic        ts_64_load_valid;
    ns_frac_t    period_in;
    logic        period_valid;
    ns_frac_t    adj_in;
    logic [15:0] adj_count;
    logic        adj_valid;
    ns_frac_t    drift_in;
    logic [15:0] drift_rate;
    logic        drift_valid;
    logic        event_in;
    logic        event_ack;
    logic [47:0] perout_start;
    logic [31:0] perout_period;
    logic [31:0] perout_width;
    logic        perout_valid;
    logic        perout_enable;
    logic        adj_active;
    ts96_t       ts_96;
    ts64_t       ts_64;
    logic        ts_step;
    logic        pps;
    ts96_t       event_ts;
    logic        event_valid;
    evt_count_t  event_count;
    logic        event_overflow;
    logic        perout;

    model_t        m;
    ts96_t         evt_q[$];
    logic          m_ovf;
    logic          m_full;
    perout_state_t po_state;
    logic [47:0]   po_start;
    logic [31:0]   po_period;
    logic [31:0]   po_width;
    logic [47:0]   po_rise;
    logic [47:0]   po_fall;
    logic          po_out;

    string       test_name = "reset";
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'h08ac41f9;

    ptp_subsys DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic ts96_t ts96_of(model_t s);
        return {s.sec, 2'b00, s.v96};
    endfunction

    // one clock edge of the time-of-day model
    function automatic model_t ref_step(model_t s);
        model_t      n;
        logic [21:0] inc;
        logic [46:0] cand;
        n = s;
        if (rst) begin
            n = '0;
            n.period     = {`PERIOD_NS_RST, `PERIOD_FNS_RST};
            n.drift      = {4'h0, `DRIFT_FNS_RST};
            n.drift_rate = `DRIFT_RATE_RST;
            return n;
        end
        n.pps = 1'b0;
        if (period_valid) begin
            n.period = period_in;
        end
        if (drift_valid) begin
            n.drift      = drift_in;
            n.drift_rate = drift_rate;
        end
        // offset window of adj_count cycles
        if (adj_valid) begin
            n.adj     = adj_in;
            n.adj_cnt = adj_count;
            n.adj_on  = (adj_count != 16'd0);
        end else if (s.adj_on) begin
            n.adj_cnt = s.adj_cnt - 16'd1;
            if (s.adj_cnt == 16'd1) begin
                n.adj_on = 1'b0;
            end
        end
        inc = {2'b00, s.period};
        if (s.adj_on) begin
            inc = inc + {{2{s.adj.ns[3]}}, s.adj};
        end
        if (s.drift_cnt == 16'd0) begin
            inc = inc + {{2{s.drift.ns[3]}}, s.drift};
        end
        n.drift_cnt = (s.drift_cnt == 16'd0) ? s.drift_rate - 16'd1 : s.drift_cnt - 16'd1;
        n.inc1 = inc;
        n.inc2 = s.inc1;
        n.inc3 = s.inc2;
        n.ts64 = ts_64_load_valid ? ts_64_load : s.ts64 + {42'd0, s.inc1};
        if (ts_96_load_valid) begin
            n.sec  = ts_96_load.sec;
            n.v96  = {ts_96_load.ns, ts_96_load.fns};
            n.hold = 1'b1;
        end else begin
            // a loaded value is held for one extra cycle
            cand = s.hold ? {1'b0, s.v96} : {1'b0, s.v96} + {25'd0, s.inc3};
            if (cand >= {`NS_PER_S, 16'h0000}) begin
                cand  = cand - {`NS_PER_S, 16'h0000};
                n.sec = s.sec + 48'd1;
                n.pps = 1'b1;
            end
            n.v96  = cand[45:0];
            n.hold = 1'b0;
        end
        n.step = ts_96_load_valid | ts_64_load_valid;
        return n;
    endfunction

    // FIFO and periodic output models run on the pre-edge time
    always @(posedge clk) begin
        if (rst) begin
            evt_q.delete();
            m_ovf    = 1'b0;
            po_state = PO_IDLE;
            po_out   = 1'b0;
            po_start = '0;
            po_rise  = '0;
            po_fall  = '0;
        end else begin
            m_full = (evt_q.size() >= `EVT_FIFO_DEPTH);
            if (event_ack && evt_q.size() != 0) begin
                void'(evt_q.pop_front());
            end
            if (event_in && !m_full) begin
                evt_q.push_back(ts96_of(m));
            end else if (event_in) begin
                m_ovf = 1'b1;
            end
            if (perout_valid) begin
                po_start  = perout_start;
                po_period = perout_period;
                po_width  = perout_width;
                po_state  = PO_IDLE;
                po_out    = 1'b0;
            end else if (!perout_enable) begin
                po_state = PO_IDLE;
                po_out   = 1'b0;
            end else if (po_state == PO_IDLE) begin
                po_rise  = po_start;
                po_state = PO_WAIT_START;
            end else if (!po_out && m.ts64.ns >= po_rise) begin
                po_out   = 1'b1;
                po_fall  = po_rise + {16'd0, po_width};
                po_rise  = po_rise + {16'd0, po_period};
                po_state = PO_RUN;
            end else if (po_out && m.ts64.ns >= po_fall) begin
                po_out = 1'b0;
            end
        end
        m = ref_step(m);
    end

    task automatic check_ts96(string what, ts96_t exp, ts96_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_ts64(string what, ts64_t exp, ts64_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(string what, evt_count_t exp, evt_count_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_cycles(string what, int exp, int act);
        if (act != exp) begin
            value_errors++;
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_ts64("ts_64", m.ts64, ts_64);
            check_ts96("ts_96", ts96_of(m), ts_96);
            check_bit("pps", m.pps, pps);
            check_bit("adj_active", m.adj_on, adj_active);
            check_bit("ts_step", m.step | m.adj_on, ts_step);
            check_count("event_count", evt_count_t'(evt_q.size()), event_count);
            check_bit("event_valid", evt_q.size() != 0, event_valid);
            check_bit("event_overflow", m_ovf, event_overflow);
            if (evt_q.size() != 0) begin
                check_ts96("event_ts", evt_q[0], event_ts);
            end
            check_bit("perout", po_out, perout);
        end
    end

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            other_errors++;
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        int i;
        int n;
        int steps;
        rst = 1'b1;
        ts_96_load = '0;
        ts_96_load_valid = 1'b0;
        ts_64_load = '0;
        ts_64_load_valid = 1'b0;
        period_in = '0;
        period_valid = 1'b0;
        adj_in = '0;
        adj_count = '0;
        adj_valid = 1'b0;
        drift_in = '0;
        drift_rate = '0;
        drift_valid = 1'b0;
        event_in = 1'b0;
        event_ack = 1'b0;
        perout_start = '0;
        perout_period = '0;
        perout_width = '0;
        perout_valid = 1'b0;
        perout_enable = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "free run";
        repeat (100) next_cycle();

        // a few increments short of one second
        test_name = "rollover";
        ts_96_load = '{sec: 48'd5, rsvd: 2'b00, ns: 30'd999_999_970, fns: 16'h0000};
        ts_64_load = '{ns: 48'd1000, fns: 16'h0000};
        ts_96_load_valid = 1'b1;
        ts_64_load_valid = 1'b1;
        next_cycle();
        ts_96_load_valid = 1'b0;
        ts_64_load_valid = 1'b0;
        n = 0;
        steps = 0;
        repeat (30) begin
            @(negedge clk);
            n += pps;
            steps += ts_step;
        end
        check_cycles("pps pulses", 1, n);
        check_cycles("ts_step pulses", 1, steps);

        test_name = "offset adjust";
        rng = xorshift(rng);
        next_cycle();
        adj_in = {rng[4] ? 4'hF : 4'h1, rng[31:16]};
        adj_count = 16'd5 + rng[3:0];
        adj_valid = 1'b1;
        next_cycle();
        adj_valid = 1'b0;
        @(negedge clk);
        n = 0;
        steps = 0;
        while (adj_active && n < 100) begin
            n++;
            steps += ts_step;
            @(negedge clk);
        end
        if (adj_active) begin
            other_errors++;
            $display("adj_active stayed high after the offset window");
        end
        check_cycles("adj_active length", adj_count, n);
        check_cycles("ts_step length", adj_count, steps);

        test_name = "period and drift";
        rng = xorshift(rng);
        next_cycle();
        period_in = {4'h5, rng[15:0]};
        period_valid = 1'b1;
        drift_in = {4'hF, 16'hFF00};
        drift_rate = 16'd3;
        drift_valid = 1'b1;
        next_cycle();
        period_valid = 1'b0;
        drift_valid = 1'b0;
        repeat (80) next_cycle();

        test_name = "event capture";
        for (i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            repeat (1 + rng[2:0]) next_cycle();
            event_in = 1'b1;
            next_cycle();
            event_in = 1'b0;
        end
        for (i = 0; i < 6; i++) begin
            n = 0;
            while (!event_valid && n < 20) begin
                next_cycle();
                n++;
            end
            if (!event_valid) begin
                other_errors++;
                $display("captured event %0d never became valid", i);
            end
            event_ack = 1'b1;
            next_cycle();
            event_ack = 1'b0;
        end
        @(negedge clk);
        check_count("drained count", 4'd0, event_count);

        test_name = "event overflow";
        next_cycle();
        event_in = 1'b1;
        repeat (9) next_cycle();
        event_in = 1'b0;
        @(negedge clk);
        check_count("full count", 4'd8, event_count);
        check_bit("overflow flag", 1'b1, event_overflow);
        next_cycle();
        n = 0;
        while (event_valid && n < 20) begin
            event_ack = 1'b1;
            next_cycle();
            n++;
        end
        event_ack = 1'b0;
        check_cycles("entries drained", 8, n);

        test_name = "periodic output";
        perout_start = m.ts64.ns + 48'd300;
        perout_period = 32'd120;
        perout_width = 32'd50;
        perout_valid = 1'b1;
        next_cycle();
        perout_valid = 1'b0;
        perout_enable = 1'b1;
        n = 0;
        while (!perout && n < 300) begin
            next_cycle();
            n++;
        end
        if (!perout) begin
            other_errors++;
            $display("perout never rose after the start time");
        end
        repeat (200) next_cycle();
        perout_enable = 1'b0;
        repeat (10) next_cycle();

        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/ptp_subsys_sva.sv ====
// PTP subsystem assertions
// Protocol checks on the top-level outputs, bound into ptp_subsys.

`timescale 1ns/1ps

module ptp_subsys_sva
    import ptp_time_pkg::*, ptp_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       pps,
    input logic       ts_step,
    input logic       event_valid,
    input evt_count_t event_count,
    input ts96_t      ts_96
);

    // one pulse per second rollover
    a_pps_single: assert property (@(posedge clk) disable iff (rst) pps |=> !pps)
        else $error("pps stayed high for two cycles");

    a_event_valid: assert property (@(posedge clk) disable iff (rst)
        event_valid == (event_count != '0))
        else $error("event_valid does not match a nonzero event_count");

    a_rsvd_zero: assert property (@(posedge clk) disable iff (rst) ts_96.rsvd == 2'b00)
        else $error("reserved bits of ts_96 are not zero");

    a_step_reset: assert property (@(posedge clk) rst |=> !ts_step)
        else $error("ts_step high after reset");

endmodule

bind ptp_subsys ptp_subsys_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .pps         (pps),
    .ts_step     (ts_step),
    .event_valid (event_valid),
    .event_count (event_count),
    .ts_96       (ts_96)
);

// ==== logic/ptp_subsys.sv ====
// PTP clock subsystem top level
// Hardware clock feeding an event timestamp capture buffer and a
// periodic output generator.

`timescale 1ns/1ps

module ptp_subsys
    import ptp_time_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ts96_t       ts_96_load,
    input  logic        ts_96_load_valid,
    input  ts64_t       ts_64_load,
    input  logic        ts_64_load_valid,
    input  ns_frac_t    period_in,
    input  logic        period_valid,
    input  ns_frac_t    adj_in,
    input  logic [15:0] adj_count,
    input  logic        adj_valid,
    input  ns_frac_t    drift_in,
    input  logic [15:0] drift_rate,
    input  logic        drift_valid,
    input  logic        event_in,
    input  logic        event_ack,
    input  logic [47:0] perout_start,
    input  logic [31:0] perout_period,
    input  logic [31:0] perout_width,
    input  logic        perout_valid,
    input  logic        perout_enable,
    output logic        adj_active,
    output ts96_t       ts_96,
    output ts64_t       ts_64,
    output logic        ts_step,
    output logic        pps,
    output ts96_t       event_ts,
    output logic        event_valid,
    output evt_count_t  event_count,
    output logic        event_overflow,
    output logic        perout
);

    ptp_clock u_clock (
        .clk              (clk),
        .rst              (rst),
        .ts_96_load       (ts_96_load),
        .ts_96_load_valid (ts_96_load_valid),
        .ts_64_load       (ts_64_load),
        .ts_64_load_valid (ts_64_load_valid),
        .period_in        (period_in),
        .period_valid     (period_valid),
        .adj_in           (adj_in),
        .adj_count        (adj_count),
        .adj_valid        (adj_valid),
        .drift_in         (drift_in),
        .drift_rate       (drift_rate),
        .drift_valid      (drift_valid),
        .adj_active       (adj_active),
        .ts_96            (ts_96),
        .ts_64            (ts_64),
        .ts_step          (ts_step),
        .pps              (pps)
    );

    // captures stamped with the 96-bit time
    ptp_event_fifo u_event_fifo (
        .clk            (clk),
        .rst            (rst),
        .ts_96          (ts_96),
        .event_in       (event_in),
        .event_ack      (event_ack),
        .event_ts       (event_ts),
        .event_valid    (event_valid),
        .event_count    (event_count),
        .event_overflow (event_overflow)
    );

    ptp_perout u_perout (
        .clk           (clk),
        .rst           (rst),
        .ts_64         (ts_64),
        .perout_start  (perout_start),
        .perout_period (perout_period),
        .perout_width  (perout_width),
        .perout_valid  (perout_valid),
        .perout_enable (perout_enable),
        .perout        (perout)
    );

endmodule

// ==== logic/ptp_perout.sv ====
// PTP periodic output
// Pulse train locked to the 64-bit time of day. Waits for the start
// time, then rises at each scheduled edge and falls width ns later;
// the next edge is the previous one plus the period.

`timescale 1ns/1ps

module ptp_perout
    import ptp_time_pkg::*, ptp_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ts64_t       ts_64,
    input  logic [47:0] perout_start,
    input  logic [31:0] perout_period,
    input  logic [31:0] perout_width,
    input  logic        perout_valid,
    input  logic        perout_enable,
    output logic        perout
);

    perout_state_t state;
    logic [47:0]   start_q;
    logic [31:0]   period_q;
    logic [31:0]   width_q;
    logic [47:0]   next_rise_q;
    logic [47:0]   next_fall_q;
    logic          rise_hit;
    logic          fall_hit;

    assign rise_hit = !perout && (ts_64.ns >= next_rise_q);
    assign fall_hit = perout && (ts_64.ns >= next_fall_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= PO_IDLE;
            perout      <= 1'b0;
            start_q     <= '0;
            period_q    <= '0;
            width_q     <= '0;
            next_rise_q <= '0;
            next_fall_q <= '0;
        end else if (perout_valid) begin
            // new schedule restarts from the start time
            start_q  <= perout_start;
            period_q <= perout_period;
            width_q  <= perout_width;
            state    <= PO_IDLE;
            perout   <= 1'b0;
        end else if (!perout_enable) begin
            state  <= PO_IDLE;
            perout <= 1'b0;
        end else begin
            case (state)
                PO_IDLE: begin
                    next_rise_q <= start_q;
                    state       <= PO_WAIT_START;
                end
                PO_WAIT_START, PO_RUN: begin
                    if (rise_hit) begin
                        perout      <= 1'b1;
                        next_fall_q <= next_rise_q + {16'd0, width_q};
                        next_rise_q <= next_rise_q + {16'd0, period_q};
                        state       <= PO_RUN;
                    end else if (fall_hit) begin
                        perout <= 1'b0;
                    end
                end
                default: state <= PO_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/ptp_event_fifo.sv ====
// Event timestamp capture buffer
// Stamps the 96-bit time on each event strobe into a circular buffer,
// presents the oldest capture and pops it on event_ack. Captures that
// find the buffer full are lost and set a sticky overflow flag.

`timescale 1ns/1ps
`include "ptp_macros.svh"

module ptp_event_fifo
    import ptp_time_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ts96_t      ts_96,
    input  logic       event_in,
    input  logic       event_ack,
    output ts96_t      event_ts,
    output logic       event_valid,
    output evt_count_t event_count,
    output logic       event_overflow
);

    localparam int PTR_W = $clog2(`EVT_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`EVT_FIFO_DEPTH - 1);

    ts96_t            mem [`EVT_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    evt_count_t       count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == evt_count_t'(`EVT_FIFO_DEPTH));
    assign push = event_in && !full;
    assign pop  = event_ack && (count_q != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= ts_96;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count_q        <= '0;
            event_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // sticky until reset
            if (event_in && full) begin
                event_overflow <= 1'b1;
            end
        end
    end

    // oldest entry shown directly from storage
    assign event_ts    = mem[rd_ptr];
    assign event_valid = (count_q != '0);
    assign event_count = count_q;

endmodule

// ==== logic/ptp_clock.sv ====
// PTP hardware clock
// Time-of-day counter with 16-bit fractional nanoseconds. Adds a period,
// a timed offset slew and a periodic drift correction every cycle, and
// keeps a 96-bit seconds/nanoseconds time and a 64-bit nanosecond time.
// Seconds roll over through a borrow lookahead; pps marks each rollover.

`timescale 1ns/1ps
`include "ptp_macros.svh"

module ptp_clock
    import ptp_time_pkg::*, ptp_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ts96_t       ts_96_load,
    input  logic        ts_96_load_valid,
    input  ts64_t       ts_64_load,
    input  logic        ts_64_load_valid,
    input  ns_frac_t    period_in,
    input  logic        period_valid,
    input  ns_frac_t    adj_in,
    input  logic [15:0] adj_count,
    input  logic        adj_valid,
    input  ns_frac_t    drift_in,
    input  logic [15:0] drift_rate,
    input  logic        drift_valid,
    output logic        adj_active,
    output ts96_t       ts_96,
    output ts64_t       ts_64,
    output logic        ts_step,
    output logic        pps
);

    ns_frac_t    period_q;
    ns_frac_t    adj_q;
    ns_frac_t    drift_q;
    logic [15:0] drift_rate_q;
    logic [15:0] drift_cnt_q;
    logic [15:0] adj_cnt_q;
    adj_state_t  adj_state;

    logic [21:0] inc_next;
    inc_t        inc_q;
    inc_t        inc_dly_q;
    logic [46:0] inc_ovf_q;

    logic [47:0] sec_q;
    logic [45:0] t96_q;
    logic [45:0] t96_inc_q;
    logic [46:0] t96_ovf_q;
    logic [46:0] ovf_diff;
    logic        rollover;

    ts64_t       ts64_q;
    logic        step_q;
    logic        pps_q;

    // setting registers
    always_ff @(posedge clk) begin
        if (rst) begin
            period_q     <= '{ns: `PERIOD_NS_RST, fns: `PERIOD_FNS_RST};
            adj_q        <= '0;
            drift_q      <= '{ns: 4'h0, fns: `DRIFT_FNS_RST};
            drift_rate_q <= `DRIFT_RATE_RST;
        end else begin
            if (period_valid) begin
                period_q <= period_in;
            end
            if (adj_valid) begin
                adj_q <= adj_in;
            end
            if (drift_valid) begin
                drift_q      <= drift_in;
                drift_rate_q <= drift_rate;
            end
        end
    end

    // offset slew runs for adj_count cycles after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            adj_state <= ADJ_IDLE;
            adj_cnt_q <= '0;
        end else if (adj_valid) begin
            adj_cnt_q <= adj_count;
            adj_state <= (adj_count != 16'd0) ? ADJ_ACTIVE : ADJ_IDLE;
        end else if (adj_state == ADJ_ACTIVE) begin
            adj_cnt_q <= adj_cnt_q - 16'd1;
            if (adj_cnt_q == 16'd1) begin
                adj_state <= ADJ_IDLE;
            end
        end
    end

    assign adj_active = (adj_state == ADJ_ACTIVE);

    // offset and drift are two's complement
    assign inc_next = {2'b00, period_q}
                    + (adj_active ? {{2{adj_q.ns[3]}}, adj_q} : 22'd0)
                    + ((drift_cnt_q == 16'd0) ? {{2{drift_q.ns[3]}}, drift_q} : 22'd0);

    // increment pipeline, second stage feeds the 96-bit count
    always_ff @(posedge clk) begin
        if (rst) begin
            drift_cnt_q <= '0;
            inc_q       <= '0;
            inc_dly_q   <= '0;
            inc_ovf_q   <= {`NS_PER_S, 16'h0000};
        end else begin
            drift_cnt_q <= (drift_cnt_q == 16'd0) ? drift_rate_q - 16'd1 : drift_cnt_q - 16'd1;
            inc_q       <= inc_next;
            inc_dly_q   <= inc_q;
            inc_ovf_q   <= {`NS_PER_S, 16'h0000} - {25'd0, inc_q};
        end
    end

    // top bit clear means the running count has passed one second
    assign ovf_diff = {1'b0, t96_inc_q} - inc_ovf_q;
    assign rollover = !t96_ovf_q[46];

    always_ff @(posedge clk) begin
        if (rst) begin
            sec_q     <= '0;
            t96_q     <= '0;
            t96_inc_q <= '0;
            t96_ovf_q <= {1'b1, 46'd0};
            pps_q     <= 1'b0;
        end else if (ts_96_load_valid) begin
            sec_q     <= ts_96_load.sec;
            t96_q     <= {ts_96_load.ns, ts_96_load.fns};
            t96_inc_q <= {ts_96_load.ns, ts_96_load.fns};
            t96_ovf_q <= {1'b1, 46'd0};
            pps_q     <= 1'b0;
        end else if (rollover) begin
            // wrapped value was precomputed by the lookahead
            sec_q     <= sec_q + 48'd1;
            t96_q     <= t96_ovf_q[45:0];
            t96_inc_q <= t96_ovf_q[45:0] + {24'd0, inc_dly_q};
            t96_ovf_q <= {1'b1, 46'd0};
            pps_q     <= 1'b1;
        end else begin
            t96_q     <= t96_inc_q;
            t96_inc_q <= t96_inc_q + {24'd0, inc_dly_q};
            t96_ovf_q <= ovf_diff;
            pps_q     <= 1'b0;
        end
    end

    // 64-bit count, one stage ahead of the 96-bit one
    always_ff @(posedge clk) begin
        if (rst) begin
            ts64_q <= '0;
        end else if (ts_64_load_valid) begin
            ts64_q <= ts_64_load;
        end else begin
            ts64_q <= ts64_q + {42'd0, inc_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= 1'b0;
        end else begin
            step_q <= ts_96_load_valid | ts_64_load_valid;
        end
    end

    assign ts_96   = {sec_q, 2'b00, t96_q};
    assign ts_64   = ts64_q;
    assign ts_step = step_q | adj_active;
    assign pps     = pps_q;

endmodule

// ==== logic/ptp_ctrl_pkg.sv ====
// PTP control state encodings
// State enums for the offset adjust counter and the periodic output.

package ptp_ctrl_pkg;

    // offset slew in progress or not
    typedef enum logic {
        ADJ_IDLE,
        ADJ_ACTIVE
    } adj_state_t;

    // periodic output sequencing
    typedef enum logic [1:0] {
        PO_IDLE,
        PO_WAIT_START,
        PO_RUN
    } perout_state_t;

endpackage

// ==== logic/ptp_time_pkg.sv ====
// PTP time types
// Timestamp layouts, the per-cycle increment and the capture buffer count.

package ptp_time_pkg;

    // seconds, reserved zero, nanoseconds, 16-bit fraction
    typedef struct packed {
        logic [47:0] sec;
        logic [1:0]  rsvd;
        logic [29:0] ns;
        logic [15:0] fns;
    } ts96_t;

    // free running nanoseconds with fraction
    typedef struct packed {
        logic [47:0] ns;
        logic [15:0] fns;
    } ts64_t;

    // period, offset and drift settings
    typedef struct packed {
        logic [3:0]  ns;
        logic [15:0] fns;
    } ns_frac_t;

    // sum of period, offset and drift, room for the carries
    typedef struct packed {
        logic [5:0]  ns;
        logic [15:0] fns;
    } inc_t;

    typedef logic [3:0] evt_count_t;

endpackage

// ==== include/ptp_macros.svh ====
// PTP clock subsystem constants
// Reset values for the period and drift registers of the time-of-day
// counter, plus the depth of the event capture buffer.

`ifndef PTP_MACROS_SVH
`define PTP_MACROS_SVH

// nanosecond rollover of the seconds field
`define NS_PER_S 31'd1_000_000_000

// reset period 6.4 ns, nanoseconds and 16-bit fraction
`define PERIOD_NS_RST 4'h6
`define PERIOD_FNS_RST 16'h6666

// drift fraction added once per drift interval
`define DRIFT_FNS_RST 16'h0002

// one drift correction every 5 cycles
`define DRIFT_RATE_RST 16'h0005

// event capture entries
`define EVT_FIFO_DEPTH 8

`endif
